//--- logic/mem_test_pkg.sv
package mem_test_pkg;

   // ***********************************************
   // host register map, byte offsets
   // ***********************************************
   localparam logic [15:0] csr_dfh       = 16'h0000;
   localparam logic [15:0] csr_id_lo     = 16'h0008;
   localparam logic [15:0] csr_id_hi     = 16'h0010;
   localparam logic [15:0] csr_scratch   = 16'h0080;
   localparam logic [15:0] csr_mem_addr  = 16'h0100;
   localparam logic [15:0] csr_mem_wdata = 16'h0108;
   localparam logic [15:0] csr_ctrl      = 16'h0110;
   localparam logic [15:0] csr_status    = 16'h0118;
   localparam logic [15:0] csr_result    = 16'h0120;
   localparam logic [15:0] csr_test_len  = 16'h0128;

   // identity words the host reads back
   localparam logic [63:0] afu_dfh   = 64'h1000_0100_0000_0000;
   localparam logic [63:0] afu_id_lo = 64'h9e3b_51c0_a7d4_6f28;
   localparam logic [63:0] afu_id_hi = 64'h4c1f_82d6_3ab0_e795;

   // ctrl word layout, launch bits are one-shot, bank bit is stored
   localparam int ctrl_wr_bit    = 0;
   localparam int ctrl_rd_bit    = 1;
   localparam int ctrl_atest_bit = 2;
   localparam int ctrl_bank_bit  = 8;

   // memory side bus widths
   localparam int amm_data_w = 512;
   localparam int amm_be_w   = 64;

   typedef enum logic [1:0] {
      cmd_none      = 2'd0,
      cmd_single_wr = 2'd1,
      cmd_single_rd = 2'd2,
      cmd_addr_test = 2'd3
   } t_cmd;

   // result word, view picked by the last command issued
   typedef union packed {
      logic [63:0] rd_word;
      struct packed {
         logic [15:0] fail_count;
         logic [15:0] zero;
         logic [31:0] first_fail_addr;
      } atest;
   } t_test_result;

endpackage

//--- logic/mmio_csr.sv
`timescale 1ns/1ps

module mmio_csr
   import mem_test_pkg::*;
(
   input  logic          Clk_400,
   input  logic          rst_n,
   // host register port
   input  logic          mmio_wr_valid,
   input  logic          mmio_rd_valid,
   input  logic [15:0]   mmio_addr,
   input  logic [63:0]   mmio_wr_data,
   output logic          mmio_rd_resp_valid,
   output logic [63:0]   mmio_rd_resp_data,
   // completion from the sequencer
   input  logic          cmd_done,
   input  t_test_result  result_word,
   input  logic          busy,
   // launch toward the sequencer
   output logic          cmd_start,
   output t_cmd          cmd_kind,
   output logic [31:0]   cmd_addr,
   output logic [63:0]   cmd_wdata,
   output logic [15:0]   cmd_len,
   output logic          mem_bank_select
);

   logic [63:0]  scratch_q;
   logic [31:0]  addr_q;
   logic [63:0]  wdata_q;
   logic [15:0]  len_q;
   t_test_result result_q;
   logic         wr_done_q;
   logic         rd_done_q;
   logic         at_done_q;
   logic         wr_ctrl;
   logic         launch_ok;
   logic         status_busy;
   t_cmd         launch_kind;
   logic [63:0]  rd_mux;

   // operands go straight from the holding registers
   assign cmd_addr  = addr_q;
   assign cmd_wdata = wdata_q;
   assign cmd_len   = len_q;

   // a launch pending in cmd_start also counts as busy
   assign status_busy = busy || cmd_start;
   assign wr_ctrl     = mmio_wr_valid && (mmio_addr == csr_ctrl);

   // one launch bit wins, write over read over test
   always_comb begin
      launch_kind = cmd_none;
      if (mmio_wr_data[ctrl_wr_bit]) begin
         launch_kind = cmd_single_wr;
      end else if (mmio_wr_data[ctrl_rd_bit]) begin
         launch_kind = cmd_single_rd;
      end else if (mmio_wr_data[ctrl_atest_bit]) begin
         launch_kind = cmd_addr_test;
      end
   end

   assign launch_ok = wr_ctrl && (launch_kind != cmd_none) && !status_busy;

   // ***********************************************
   // control state, launch and completion
   // ***********************************************
   always_ff @(posedge Clk_400) begin
      if (!rst_n) begin
         scratch_q          <= '0;
         result_q           <= '0;
         cmd_start          <= 1'b0;
         cmd_kind           <= cmd_none;
         wr_done_q          <= 1'b0;
         rd_done_q          <= 1'b0;
         at_done_q          <= 1'b0;
         mem_bank_select    <= 1'b0;
         mmio_rd_resp_valid <= 1'b0;
      end else begin
         // response strobe trails the request by one cycle
         mmio_rd_resp_valid <= mmio_rd_valid;
         cmd_start          <= launch_ok;
         if (mmio_wr_valid && (mmio_addr == csr_scratch)) begin
            scratch_q <= mmio_wr_data;
         end
         if (wr_ctrl) begin
            mem_bank_select <= mmio_wr_data[ctrl_bank_bit];
         end
         // cmd_kind still names the command that just finished
         if (cmd_done) begin
            result_q <= result_word;
            case (cmd_kind)
               cmd_single_wr: wr_done_q <= 1'b1;
               cmd_single_rd: rd_done_q <= 1'b1;
               cmd_addr_test: at_done_q <= 1'b1;
               default: ;
            endcase
         end
         // new launch clears every done flag
         if (launch_ok) begin
            cmd_kind  <= launch_kind;
            wr_done_q <= 1'b0;
            rd_done_q <= 1'b0;
            at_done_q <= 1'b0;
         end
      end
   end

   // operand registers and read data
   always_ff @(posedge Clk_400) begin
      if (mmio_wr_valid) begin
         case (mmio_addr)
            csr_mem_addr:  addr_q  <= mmio_wr_data[31:0];
            csr_mem_wdata: wdata_q <= mmio_wr_data;
            csr_test_len:  len_q   <= mmio_wr_data[15:0];
            default: ;
         endcase
      end
      mmio_rd_resp_data <= rd_mux;
   end

   // readback select, unmapped offsets give zero
   always_comb begin
      rd_mux = '0;
      case (mmio_addr)
         csr_dfh:       rd_mux = afu_dfh;
         csr_id_lo:     rd_mux = afu_id_lo;
         csr_id_hi:     rd_mux = afu_id_hi;
         csr_scratch:   rd_mux = scratch_q;
         csr_mem_addr:  rd_mux = {32'd0, addr_q};
         csr_mem_wdata: rd_mux = wdata_q;
         csr_ctrl:      rd_mux[ctrl_bank_bit] = mem_bank_select;
         csr_status:    rd_mux = {60'd0, at_done_q, rd_done_q, wr_done_q, status_busy};
         csr_result:    rd_mux = result_q;
         csr_test_len:  rd_mux = {48'd0, len_q};
         default:       rd_mux = '0;
      endcase
   end

endmodule

//--- logic/mem_test_fsm.sv
`timescale 1ns/1ps

module mem_test_fsm
   import mem_test_pkg::*;
#(
   parameter int ADDR_W = 32
) (
   input  logic              Clk_400,
   input  logic              rst_n,
   // command from the register file
   input  logic              cmd_start,
   input  t_cmd              cmd_kind,
   input  logic [31:0]       cmd_addr,
   input  logic [63:0]       cmd_wdata,
   input  logic [15:0]       cmd_len,
   output logic              busy,
   output logic              cmd_done,
   output t_test_result      result_word,
   // request toward the bus stage
   output logic              amm_req_valid,
   output logic              amm_req_write,
   output logic [ADDR_W-1:0] amm_req_addr,
   output logic [63:0]       amm_req_wdata,
   input  logic              amm_req_ready,
   // registered read return
   input  logic              amm_rsp_valid,
   input  logic [63:0]       amm_rsp_data
);

   // state encodings
   localparam logic [2:0] st_idle     = 3'd0;
   localparam logic [2:0] st_wr_req   = 3'd1;
   localparam logic [2:0] st_wr_flush = 3'd2;
   localparam logic [2:0] st_rd_req   = 3'd3;
   localparam logic [2:0] st_rd_wait  = 3'd4;
   localparam logic [2:0] st_at_wr    = 3'd5;
   localparam logic [2:0] st_at_rd    = 3'd6;
   localparam logic [2:0] st_at_wait  = 3'd7;

   logic [2:0]        state_q;
   logic [15:0]       idx_q;
   logic [15:0]       len_q;
   logic [ADDR_W-1:0] base_addr_q;
   logic [ADDR_W-1:0] cur_addr_q;
   logic [63:0]       wdata_q;
   t_test_result      result_q;
   logic              xfer;
   logic              last;
   logic [63:0]       expect_word;

   assign busy        = (state_q != st_idle);
   assign result_word = result_q;

   // ***********************************************
   // request outputs decoded from state
   // ***********************************************
   assign amm_req_valid = (state_q == st_wr_req) || (state_q == st_rd_req) ||
                          (state_q == st_at_wr)  || (state_q == st_at_rd);
   assign amm_req_write = (state_q == st_wr_req) || (state_q == st_at_wr);
   assign amm_req_addr  = cur_addr_q;
   // test writes carry their own byte address
   assign expect_word   = 64'(cur_addr_q);
   assign amm_req_wdata = (state_q == st_at_wr) ? expect_word : wdata_q;

   assign xfer = amm_req_valid && amm_req_ready;
   assign last = (idx_q == len_q - 16'd1);

   // sequencing
   always_ff @(posedge Clk_400) begin
      if (!rst_n) begin
         state_q  <= st_idle;
         idx_q    <= '0;
         cmd_done <= 1'b0;
      end else begin
         cmd_done <= 1'b0;
         case (state_q)
            st_idle: begin
               if (cmd_start) begin
                  idx_q <= '0;
                  case (cmd_kind)
                     cmd_single_wr: state_q <= st_wr_req;
                     cmd_single_rd: state_q <= st_rd_req;
                     cmd_addr_test: begin
                        // empty range finishes at once
                        if (cmd_len == 16'd0) begin
                           cmd_done <= 1'b1;
                        end else begin
                           state_q <= st_at_wr;
                        end
                     end
                     default: ;
                  endcase
               end
            end
            st_wr_req: if (xfer) state_q <= st_wr_flush;
            // wait until the bus stage has handed the write on
            st_wr_flush: begin
               if (amm_req_ready) begin
                  state_q  <= st_idle;
                  cmd_done <= 1'b1;
               end
            end
            st_rd_req: if (xfer) state_q <= st_rd_wait;
            st_rd_wait: begin
               if (amm_rsp_valid) begin
                  state_q  <= st_idle;
                  cmd_done <= 1'b1;
               end
            end
            st_at_wr: begin
               if (xfer) begin
                  if (last) begin
                     idx_q   <= '0;
                     state_q <= st_at_rd;
                  end else begin
                     idx_q <= idx_q + 16'd1;
                  end
               end
            end
            st_at_rd: if (xfer) state_q <= st_at_wait;
            // one read in flight, next one after the compare
            st_at_wait: begin
               if (amm_rsp_valid) begin
                  if (last) begin
                     state_q  <= st_idle;
                     cmd_done <= 1'b1;
                  end else begin
                     idx_q   <= idx_q + 16'd1;
                     state_q <= st_at_rd;
                  end
               end
            end
            default: state_q <= st_idle;
         endcase
      end
   end

   // address walk and result capture
   always_ff @(posedge Clk_400) begin
      if ((state_q == st_idle) && cmd_start) begin
         base_addr_q      <= ADDR_W'(cmd_addr);
         cur_addr_q       <= ADDR_W'(cmd_addr);
         wdata_q          <= cmd_wdata;
         len_q            <= cmd_len;
         // a write reports the word it stored
         result_q.rd_word <= (cmd_kind == cmd_single_wr) ? cmd_wdata : 64'd0;
      end
      // rewind to the base once the last test write is taken
      if ((state_q == st_at_wr) && xfer) begin
         cur_addr_q <= last ? base_addr_q : cur_addr_q + ADDR_W'(8);
      end
      if ((state_q == st_rd_wait) && amm_rsp_valid) begin
         result_q.rd_word <= amm_rsp_data;
      end
      if ((state_q == st_at_wait) && amm_rsp_valid) begin
         if (amm_rsp_data != expect_word) begin
            if (result_q.atest.fail_count == 16'd0) begin
               result_q.atest.first_fail_addr <= 32'(cur_addr_q);
            end
            result_q.atest.fail_count <= result_q.atest.fail_count + 16'd1;
         end
         cur_addr_q <= cur_addr_q + ADDR_W'(8);
      end
   end

endmodule

//--- logic/amm_io_regs.sv
`timescale 1ns/1ps

module amm_io_regs
   import mem_test_pkg::*;
#(
   parameter int ADDR_W = 32
) (
   input  logic                  Clk_400,
   input  logic                  rst_n,
   // request from the sequencer
   input  logic                  amm_req_valid,
   input  logic                  amm_req_write,
   input  logic [ADDR_W-1:0]     amm_req_addr,
   input  logic [63:0]           amm_req_wdata,
   output logic                  amm_req_ready,
   output logic                  amm_rsp_valid,
   output logic [63:0]           amm_rsp_data,
   // avalon master side
   output logic [ADDR_W-1:0]     avs_address,
   output logic                  avs_write,
   output logic                  avs_read,
   output logic [amm_data_w-1:0] avs_writedata,
   output logic [amm_be_w-1:0]   avs_byteenable,
   output logic [11:0]           avs_burstcount,
   input  logic                  avs_waitrequest,
   input  logic [amm_data_w-1:0] avs_readdata,
   input  logic                  avs_readdatavalid
);

   logic req_load;

   // slot is free when empty or the bus takes it this cycle
   assign amm_req_ready = !(avs_read || avs_write) || !avs_waitrequest;
   assign req_load      = amm_req_valid && amm_req_ready;

   // single beats on the low quadword only
   assign avs_byteenable = {{(amm_be_w-8){1'b0}}, 8'hff};
   assign avs_burstcount = 12'd1;

   always_ff @(posedge Clk_400) begin
      if (!rst_n) begin
         avs_read      <= 1'b0;
         avs_write     <= 1'b0;
         amm_rsp_valid <= 1'b0;
      end else begin
         // strobes only move when the slot turns over
         if (amm_req_ready) begin
            avs_write <= req_load && amm_req_write;
            avs_read  <= req_load && !amm_req_write;
         end
         amm_rsp_valid <= avs_readdatavalid;
      end
   end

   // command fields held while waitrequest is up
   always_ff @(posedge Clk_400) begin
      if (req_load) begin
         avs_address   <= amm_req_addr;
         avs_writedata <= {{(amm_data_w-64){1'b0}}, amm_req_wdata};
      end
      amm_rsp_data <= avs_readdata[63:0];
   end

endmodule

//--- logic/mem_test_afu.sv
`timescale 1ns/1ps

module mem_test_afu
   import mem_test_pkg::*;
#(
   parameter int ADDR_W = 32
) (
   input  logic                  Clk_400,
   input  logic                  rst_n,
   // host register port
   input  logic                  mmio_wr_valid,
   input  logic                  mmio_rd_valid,
   input  logic [15:0]           mmio_addr,
   input  logic [63:0]           mmio_wr_data,
   output logic                  mmio_rd_resp_valid,
   output logic [63:0]           mmio_rd_resp_data,
   // avalon memory port
   output logic [ADDR_W-1:0]     avs_address,
   output logic                  avs_write,
   output logic                  avs_read,
   output logic [amm_data_w-1:0] avs_writedata,
   output logic [amm_be_w-1:0]   avs_byteenable,
   output logic [11:0]           avs_burstcount,
   input  logic                  avs_waitrequest,
   input  logic [amm_data_w-1:0] avs_readdata,
   input  logic                  avs_readdatavalid,
   output logic                  mem_bank_select
);

   // register file to sequencer
   logic              cmd_start;
   t_cmd              cmd_kind;
   logic [31:0]       cmd_addr;
   logic [63:0]       cmd_wdata;
   logic [15:0]       cmd_len;
   logic              cmd_done;
   logic              busy;
   t_test_result      result_word;
   // sequencer to bus stage
   logic              amm_req_valid;
   logic              amm_req_write;
   logic [ADDR_W-1:0] amm_req_addr;
   logic [63:0]       amm_req_wdata;
   logic              amm_req_ready;
   logic              amm_rsp_valid;
   logic [63:0]       amm_rsp_data;

   mmio_csr csr (
      .Clk_400            (Clk_400),
      .rst_n              (rst_n),
      .mmio_wr_valid      (mmio_wr_valid),
      .mmio_rd_valid      (mmio_rd_valid),
      .mmio_addr          (mmio_addr),
      .mmio_wr_data       (mmio_wr_data),
      .mmio_rd_resp_valid (mmio_rd_resp_valid),
      .mmio_rd_resp_data  (mmio_rd_resp_data),
      .cmd_done           (cmd_done),
      .result_word        (result_word),
      .busy               (busy),
      .cmd_start          (cmd_start),
      .cmd_kind           (cmd_kind),
      .cmd_addr           (cmd_addr),
      .cmd_wdata          (cmd_wdata),
      .cmd_len            (cmd_len),
      .mem_bank_select    (mem_bank_select)
   );

   mem_test_fsm #(
      .ADDR_W (ADDR_W)
   ) fsm (
      .Clk_400       (Clk_400),
      .rst_n         (rst_n),
      .cmd_start     (cmd_start),
      .cmd_kind      (cmd_kind),
      .cmd_addr      (cmd_addr),
      .cmd_wdata     (cmd_wdata),
      .cmd_len       (cmd_len),
      .busy          (busy),
      .cmd_done      (cmd_done),
      .result_word   (result_word),
      .amm_req_valid (amm_req_valid),
      .amm_req_write (amm_req_write),
      .amm_req_addr  (amm_req_addr),
      .amm_req_wdata (amm_req_wdata),
      .amm_req_ready (amm_req_ready),
      .amm_rsp_valid (amm_rsp_valid),
      .amm_rsp_data  (amm_rsp_data)
   );

   // every avalon signal passes through this stage
   amm_io_regs #(
      .ADDR_W (ADDR_W)
   ) io (
      .Clk_400           (Clk_400),
      .rst_n             (rst_n),
      .amm_req_valid     (amm_req_valid),
      .amm_req_write     (amm_req_write),
      .amm_req_addr      (amm_req_addr),
      .amm_req_wdata     (amm_req_wdata),
      .amm_req_ready     (amm_req_ready),
      .amm_rsp_valid     (amm_rsp_valid),
      .amm_rsp_data      (amm_rsp_data),
      .avs_address       (avs_address),
      .avs_write         (avs_write),
      .avs_read          (avs_read),
      .avs_writedata     (avs_writedata),
      .avs_byteenable    (avs_byteenable),
      .avs_burstcount    (avs_burstcount),
      .avs_waitrequest   (avs_waitrequest),
      .avs_readdata      (avs_readdata),
      .avs_readdatavalid (avs_readdatavalid)
   );

endmodule

//--- tests/tb_mem_test_afu.sv
`timescale 1ns/1ps

module tb_mem_test_afu
   import mem_test_pkg::*;
();

   localparam logic [31:0] lcg_seed   = 32'h8454_051a;
   localparam int          poll_limit = 2000;

   logic                  Clk_400;
   logic                  rst_n;
   logic                  mmio_wr_valid;
   logic                  mmio_rd_valid;
   logic [15:0]           mmio_addr;
   logic [63:0]           mmio_wr_data;
   logic                  mmio_rd_resp_valid;
   logic [63:0]           mmio_rd_resp_data;
   logic [31:0]           avs_address;
   logic                  avs_write;
   logic                  avs_read;
   logic [amm_data_w-1:0] avs_writedata;
   logic [amm_be_w-1:0]   avs_byteenable;
   logic [11:0]           avs_burstcount;
   logic                  avs_waitrequest   = 1'b0;
   logic [amm_data_w-1:0] avs_readdata      = '0;
   logic                  avs_readdatavalid = 1'b0;
   logic                  mem_bank_select;

   // memory model state, written by the model process only
   logic [63:0]           mem [0:255];
   logic [31:0]           mem_rng    = lcg_seed ^ 32'h5bd1_e995;
   int                    cyc        = 0;
   int                    rsp_due [$];
   logic [63:0]           rsp_data [$];
   logic                  hold_valid = 1'b0;
   logic                  hold_rd;
   logic                  hold_wr;
   logic [31:0]           hold_addr;
   logic [63:0]           hold_wdata;
   // fault injection, only touched while the bus is idle
   logic                  fault_en;
   logic [7:0]            fault_idx;
   logic [63:0]           fault_mask;
   logic [31:0]           stim_rng;

   mem_test_afu UUT (
      .Clk_400            (Clk_400),
      .rst_n              (rst_n),
      .mmio_wr_valid      (mmio_wr_valid),
      .mmio_rd_valid      (mmio_rd_valid),
      .mmio_addr          (mmio_addr),
      .mmio_wr_data       (mmio_wr_data),
      .mmio_rd_resp_valid (mmio_rd_resp_valid),
      .mmio_rd_resp_data  (mmio_rd_resp_data),
      .avs_address        (avs_address),
      .avs_write          (avs_write),
      .avs_read           (avs_read),
      .avs_writedata      (avs_writedata),
      .avs_byteenable     (avs_byteenable),
      .avs_burstcount     (avs_burstcount),
      .avs_waitrequest    (avs_waitrequest),
      .avs_readdata       (avs_readdata),
      .avs_readdatavalid  (avs_readdatavalid),
      .mem_bank_select    (mem_bank_select)
   );

   // 100 ns period, first rising edge at 50 ns
   initial begin
      Clk_400 = 1'b0;
      forever #50 Clk_400 = ~Clk_400;
   end

   // **************************************************
   // random numbers, failure reporting and checks
   // **************************************************
   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic draw32(output logic [31:0] v);
      stim_rng = lcg_step(stim_rng);
      v = stim_rng;
   endtask

   task automatic draw64(output logic [63:0] v);
      logic [31:0] hi;
      logic [31:0] lo;
      draw32(hi);
      draw32(lo);
      v = {hi, lo};
   endtask

   task automatic stop_run();
      $display("=== FAIL ===");
      $fatal(1, "stopping at first error");
   endtask

   task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
         stop_run();
      end
   endtask

   // **************************************************
   // host register port, called on a falling edge
   // **************************************************
   task automatic mmio_write(input logic [15:0] addr, input logic [63:0] data);
      mmio_wr_valid = 1'b1;
      mmio_addr     = addr;
      mmio_wr_data  = data;
      @(negedge Clk_400);
      mmio_wr_valid = 1'b0;
   endtask

   // response must show up in the very next cycle and only there
   task automatic mmio_read(input logic [15:0] addr, output logic [63:0] data);
      mmio_rd_valid = 1'b1;
      mmio_addr     = addr;
      @(negedge Clk_400);
      mmio_rd_valid = 1'b0;
      check_eq("mmio_rd_resp_valid", {63'd0, mmio_rd_resp_valid}, 64'd1);
      data = mmio_rd_resp_data;
      @(negedge Clk_400);
      check_eq("mmio_rd_resp_valid", {63'd0, mmio_rd_resp_valid}, 64'd0);
   endtask

   // poll status until the done bit rises
   task automatic wait_status(input int done_bit, input string what, output logic [63:0] st);
      int tries;
      tries = 0;
      st = '0;
      while (st[done_bit] !== 1'b1) begin
         if (tries >= poll_limit) begin
            $display("ERROR at %0t: no %s within %0d status polls", $time, what, poll_limit);
            stop_run();
         end else begin
            mmio_read(csr_status, st);
            tries++;
         end
      end
      check_eq("status busy", {63'd0, st[0]}, 64'd0);
   endtask

   task automatic run_addr_test(input logic [31:0] base, input int len,
                                output t_test_result res);
      logic [63:0] st;
      logic [63:0] word;
      mmio_write(csr_mem_addr, {32'd0, base});
      mmio_write(csr_test_len, 64'(len));
      mmio_write(csr_ctrl, 64'd1 << ctrl_atest_bit);
      wait_status(3, "address test done", st);
      mmio_read(csr_result, word);
      res = word;
   endtask

   // **************************************************
   // avalon memory model
   // **************************************************
   always @(negedge Clk_400) begin : avalon_model
      logic       req;
      logic [7:0] idx;
      int         due;
      int         k;

      cyc = cyc + 1;
      if (!rst_n) begin
         // fill pattern from the whole word index
         for (k = 0; k < 256; k++) begin
            mem[8'(k)] = {8'h5a, 8'(k), 16'(k * 7), ~32'(k) * 32'h9e37_79b9};
         end
      end
      req = avs_read || avs_write;
      // stalled request keeps every field
      if (hold_valid) begin
         check_eq("avs_read", {63'd0, avs_read}, {63'd0, hold_rd});
         check_eq("avs_write", {63'd0, avs_write}, {63'd0, hold_wr});
         check_eq("avs_address", {32'd0, avs_address}, {32'd0, hold_addr});
         check_eq("avs_writedata", avs_writedata[63:0], hold_wdata);
      end
      if (avs_write) begin
         check_eq("avs_writedata upper", {63'd0, |avs_writedata[amm_data_w-1:64]}, 64'd0);
         check_eq("avs_byteenable", avs_byteenable, 64'h0000_0000_0000_00ff);
         check_eq("avs_burstcount", {52'd0, avs_burstcount}, 64'd1);
      end
      // about one cycle in four stalls
      mem_rng         = lcg_step(mem_rng);
      avs_waitrequest = (mem_rng[31:30] == 2'b11);
      hold_valid      = req && avs_waitrequest;
      hold_rd         = avs_read;
      hold_wr         = avs_write;
      hold_addr       = avs_address;
      hold_wdata      = avs_writedata[63:0];
      // accepted at the coming rising edge
      if (req && !avs_waitrequest) begin
         idx = avs_address[10:3];
         if (avs_write) begin
            if (fault_en && (idx == fault_idx)) begin
               mem[idx] = avs_writedata[63:0] ^ fault_mask;
            end else begin
               mem[idx] = avs_writedata[63:0];
            end
         end else begin
            // read latency 1 to 4, kept in order
            mem_rng = lcg_step(mem_rng);
            due = cyc + 1 + int'(mem_rng[29:28]);
            if ((rsp_due.size() > 0) && (due <= rsp_due[$])) begin
               due = rsp_due[$] + 1;
            end
            rsp_due.push_back(due);
            rsp_data.push_back(mem[idx]);
         end
      end
      avs_readdatavalid = 1'b0;
      if ((rsp_due.size() > 0) && (rsp_due[0] <= cyc)) begin
         avs_readdatavalid = 1'b1;
         // upper lanes are junk the DUT must drop
         avs_readdata = {{(amm_data_w-64){1'b1}}, rsp_data.pop_front()};
         void'(rsp_due.pop_front());
      end
   end

   // **************************************************
   // scenarios
   // **************************************************
   initial begin : stimulus
      logic [31:0]  r;
      logic [31:0]  addr;
      logic [63:0]  val;
      logic [63:0]  rd;
      logic [63:0]  st;
      t_test_result res;
      int           base_idx;
      int           len;
      int           k;

      stim_rng      = lcg_seed;
      fault_en      = 1'b0;
      fault_idx     = '0;
      fault_mask    = '0;
      rst_n         = 1'b0;
      mmio_wr_valid = 1'b0;
      mmio_rd_valid = 1'b0;
      mmio_addr     = '0;
      mmio_wr_data  = '0;
      repeat (5) @(negedge Clk_400);
      rst_n = 1'b1;
      @(negedge Clk_400);

      // reset values, then identity and idle status
      check_eq("avs_read", {63'd0, avs_read}, 64'd0);
      check_eq("avs_write", {63'd0, avs_write}, 64'd0);
      check_eq("mmio_rd_resp_valid", {63'd0, mmio_rd_resp_valid}, 64'd0);
      check_eq("mem_bank_select", {63'd0, mem_bank_select}, 64'd0);
      mmio_read(csr_dfh, rd);
      check_eq("csr_dfh", rd, afu_dfh);
      mmio_read(csr_id_lo, rd);
      check_eq("csr_id_lo", rd, afu_id_lo);
      mmio_read(csr_id_hi, rd);
      check_eq("csr_id_hi", rd, afu_id_hi);
      mmio_read(csr_status, rd);
      check_eq("csr_status", rd, 64'd0);
      mmio_read(csr_result, rd);
      check_eq("csr_result", rd, 64'd0);

      // scratch round trips
      for (k = 0; k < 8; k++) begin
         draw64(val);
         mmio_write(csr_scratch, val);
         mmio_read(csr_scratch, rd);
         check_eq("csr_scratch", rd, val);
      end

      // single writes land in the model memory
      for (k = 0; k < 6; k++) begin
         draw32(r);
         addr = {r[31:3], 3'b000};
         draw64(val);
         mmio_write(csr_mem_addr, {32'd0, addr});
         mmio_write(csr_mem_wdata, val);
         mmio_write(csr_ctrl, 64'd1 << ctrl_wr_bit);
         wait_status(1, "write done", st);
         check_eq("memory word after write", mem[addr[10:3]], val);
      end

      // single reads, the first one hits the last write
      for (k = 0; k < 4; k++) begin
         if (k != 0) begin
            draw32(r);
            addr = {r[31:3], 3'b000};
         end
         mmio_write(csr_mem_addr, {32'd0, addr});
         mmio_write(csr_ctrl, 64'd1 << ctrl_rd_bit);
         wait_status(2, "read done", st);
         mmio_read(csr_result, rd);
         check_eq("csr_result read word", rd, mem[addr[10:3]]);
      end

      // address test on a clean memory
      draw32(r);
      base_idx = int'(r % 32'd224);
      draw32(r);
      len = 1 + int'(r[4:0]);
      run_addr_test(32'(base_idx * 8), len, res);
      check_eq("fail_count", {48'd0, res.atest.fail_count}, 64'd0);
      check_eq("result zero field", {48'd0, res.atest.zero}, 64'd0);
      for (k = 0; k < len; k++) begin
         check_eq("memory word after test", mem[8'(base_idx + k)], 64'(base_idx * 8 + k * 8));
      end

      // address test with one corrupted word
      draw32(r);
      base_idx = int'(r % 32'd224);
      draw32(r);
      len = 1 + int'(r[4:0]);
      draw32(r);
      k = int'(r % 32'(len));
      draw32(r);
      fault_mask = {32'd0, r | 32'd1};
      fault_idx  = 8'(base_idx + k);
      fault_en   = 1'b1;
      run_addr_test(32'(base_idx * 8), len, res);
      fault_en   = 1'b0;
      check_eq("fail_count", {48'd0, res.atest.fail_count}, 64'd1);
      check_eq("first_fail_addr", {32'd0, res.atest.first_fail_addr}, 64'(base_idx * 8 + k * 8));

      // bank bit is stored, no launch
      mmio_write(csr_ctrl, 64'd1 << ctrl_bank_bit);
      check_eq("mem_bank_select", {63'd0, mem_bank_select}, 64'd1);
      mmio_read(csr_ctrl, rd);
      check_eq("csr_ctrl", rd, 64'd1 << ctrl_bank_bit);

      $display("=== PASS ===");
      $finish;
   end

endmodule

//--- sources.f
logic/mem_test_pkg.sv
logic/mmio_csr.sv
logic/mem_test_fsm.sv
logic/amm_io_regs.sv
logic/mem_test_afu.sv
tests/tb_mem_test_afu.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it, pass only on the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
   --top-module tb_mem_test_afu \
   -f sources.f \
   -o tb_sim \
   && ./obj_dir/tb_sim | tee /dev/stderr | grep -q -F "=== PASS ===" \
   && echo "run.sh: simulation passed" \
   || { echo "run.sh: simulation failed"; exit 1; }

exit 0
